// ==== files.f ====
+incdir+verification
logic/sched_pkg.sv
logic/address_decoder.sv
logic/bank_request_fifo.sv
logic/bank_controller.sv
logic/command_arbiter.sv
logic/request_scheduler.sv
verification/request_scheduler_tb.sv

// ==== logic/address_decoder.sv ====
module address_decoder import sched_pkg::*; (
    input  logic [ADDR_BITS-1:0] addr,
    input  logic                 req_valid,
    output logic [BG_BITS-1:0]   bank_group,
    output logic [BA_BITS-1:0]   bank,
    output logic [ROW_BITS-1:0]  row,
    output logic [COL_BITS-1:0]  col,
    output logic [BANK_BITS-1:0] bank_index,
    output logic [NUM_BANKS-1:0] push
);

    // field slicing, bank group sits on top
    assign bank_group = addr[ADDR_BITS-1 -: BG_BITS];
    assign bank       = addr[ADDR_BITS-BG_BITS-1 -: BA_BITS];
    assign row        = addr[COL_BITS +: ROW_BITS];
    assign col        = addr[COL_BITS-1:0];

    assign bank_index = {bank_group, bank};  // group-major numbering

    // one-hot push toward the selected bank queue
    always_comb begin
        push = '0;
        if (req_valid) begin
            push[bank_index] = 1'b1;
        end
    end

endmodule

// ==== logic/bank_controller.sv ====
module bank_controller import sched_pkg::*; (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 head_valid,
    input  logic                 head_write,
    input  logic [ROW_BITS-1:0]  head_row,
    input  logic [COL_BITS-1:0]  head_col,
    input  logic [DATA_BITS-1:0] head_data,
    input  logic                 grant,
    input  logic                 issued,
    output logic                 pop,
    output logic                 want,
    output cmd_e                 want_kind,
    output logic [ROW_BITS-1:0]  want_row,
    output logic [COL_BITS-1:0]  want_col,
    output logic [DATA_BITS-1:0] want_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,     // asking the arbiter
        ST_WAIT_ISSUE,  // granted, command sits in the output register
        ST_TIMING       // precharge or activate latency running
    } state_e;

    state_e                 state;
    logic                   open_valid;
    logic [ROW_BITS-1:0]    open_row;
    logic [TIMER_BITS-1:0]  timer;
    logic                   is_access;

    // next command for the head request, from the open-row state
    always_comb begin
        if (open_valid && (open_row == head_row)) begin
            want_kind = head_write ? CMD_WRITE : CMD_READ;
        end else if (open_valid) begin
            want_kind = CMD_PRECHARGE;  // row miss
        end else begin
            want_kind = CMD_ACTIVATE;   // bank closed
        end
    end

    assign is_access = (want_kind == CMD_READ) || (want_kind == CMD_WRITE);

    assign want      = (state == ST_REQUEST);
    assign want_row  = head_row;
    assign want_col  = head_col;
    assign want_data = head_data;

    // the request leaves the queue once its read or write is on the bus
    assign pop = (state == ST_WAIT_ISSUE) && issued && is_access;

    // the timer load leaves out three cycles: the timer-to-request step,
    // the grant cycle and the cycle in the output register
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state      <= ST_IDLE;
            open_valid <= 1'b0;
            open_row   <= '0;
            timer      <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (head_valid) begin
                        state <= ST_REQUEST;
                    end
                end
                ST_REQUEST: begin
                    if (grant) begin
                        state <= ST_WAIT_ISSUE;
                    end
                end
                ST_WAIT_ISSUE: begin
                    if (issued) begin
                        case (want_kind)
                            CMD_ACTIVATE: begin
                                open_valid <= 1'b1;
                                open_row   <= head_row;
                                timer      <= TIMER_BITS'(ACTIVATE_CYCLES - 3);
                                state      <= ST_TIMING;
                            end
                            CMD_PRECHARGE: begin
                                open_valid <= 1'b0;
                                timer      <= TIMER_BITS'(PRECHARGE_CYCLES - 3);
                                state      <= ST_TIMING;
                            end
                            default: begin
                                state <= ST_IDLE;  // access done, row stays open
                            end
                        endcase
                    end
                end
                default: begin
                    // head is still the same request after act or pre
                    if (timer == '0) begin
                        state <= ST_REQUEST;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== logic/bank_request_fifo.sv ====
module bank_request_fifo import sched_pkg::*; (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 push,
    input  logic                 write,
    input  logic [ROW_BITS-1:0]  row,
    input  logic [COL_BITS-1:0]  col,
    input  logic [DATA_BITS-1:0] data,
    input  logic                 pop,
    output logic                 full,
    output logic                 head_valid,
    output logic                 head_write,
    output logic [ROW_BITS-1:0]  head_row,
    output logic [COL_BITS-1:0]  head_col,
    output logic [DATA_BITS-1:0] head_data
);

    logic                 mem_write [FIFO_DEPTH];
    logic [ROW_BITS-1:0]  mem_row   [FIFO_DEPTH];
    logic [COL_BITS-1:0]  mem_col   [FIFO_DEPTH];
    logic [DATA_BITS-1:0] mem_data  [FIFO_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                do_push;
    logic                do_pop;

    assign full       = (count == (PTR_BITS+1)'(FIFO_DEPTH));
    assign head_valid = (count != '0);
    assign do_push    = push && !full;  // a push into a full queue is dropped
    assign do_pop     = pop && head_valid;

    assign head_write = mem_write[rd_ptr];
    assign head_row   = mem_row[rd_ptr];
    assign head_col   = mem_col[rd_ptr];
    assign head_data  = mem_data[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem_write[wr_ptr] <= write;
            mem_row[wr_ptr]   <= row;
            mem_col[wr_ptr]   <= col;
            mem_data[wr_ptr]  <= data;
        end
    end

    // depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== logic/command_arbiter.sv ====
module command_arbiter import sched_pkg::*; (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic [NUM_BANKS-1:0] want,
    input  cmd_e                 want_kind [NUM_BANKS],
    input  logic [ROW_BITS-1:0]  want_row  [NUM_BANKS],
    input  logic [COL_BITS-1:0]  want_col  [NUM_BANKS],
    input  logic [DATA_BITS-1:0] want_data [NUM_BANKS],
    input  logic                 cmd_ready,
    output logic [NUM_BANKS-1:0] grant,
    output logic [NUM_BANKS-1:0] issued,
    output logic                 cmd_valid,
    output cmd_e                 cmd_kind,
    output logic [BG_BITS-1:0]   cmd_bank_group,
    output logic [BA_BITS-1:0]   cmd_bank,
    output logic [ROW_BITS-1:0]  cmd_row,
    output logic [COL_BITS-1:0]  cmd_col,
    output logic [DATA_BITS-1:0] cmd_data
);

    logic                 found;
    logic [1:0]           best_rank;
    logic [BANK_BITS-1:0] sel_idx;
    logic [BANK_BITS-1:0] owner;   // bank of the held command
    logic                 load;

    // read/write over activate over precharge
    function automatic logic [1:0] class_rank(input cmd_e kind);
        case (kind)
            CMD_READ, CMD_WRITE: class_rank = 2'd2;
            CMD_ACTIVATE:        class_rank = 2'd1;
            default:             class_rank = 2'd0;
        endcase
    endfunction

    // strict compare keeps the lowest index inside a class
    always_comb begin
        found     = 1'b0;
        best_rank = '0;
        sel_idx   = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (want[i] && (!found || (class_rank(want_kind[i]) > best_rank))) begin
                found     = 1'b1;
                best_rank = class_rank(want_kind[i]);
                sel_idx   = BANK_BITS'(i);
            end
        end
    end

    assign load = found && (!cmd_valid || cmd_ready);  // empty or draining

    always_comb begin
        grant = '0;
        if (load) begin
            grant[sel_idx] = 1'b1;
        end
    end

    always_comb begin
        issued = '0;
        if (cmd_valid && cmd_ready) begin
            issued[owner] = 1'b1;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            cmd_valid <= 1'b0;
            owner     <= '0;
        end else if (load) begin
            cmd_valid <= 1'b1;
            owner     <= sel_idx;
        end else if (cmd_ready) begin
            cmd_valid <= 1'b0;
        end
    end

    // command fields, held while the sink stalls
    always_ff @(posedge clk_in) begin
        if (load) begin
            cmd_kind       <= want_kind[sel_idx];
            cmd_bank_group <= sel_idx[BANK_BITS-1:BA_BITS];
            cmd_bank       <= sel_idx[BA_BITS-1:0];
            cmd_row        <= want_row[sel_idx];
            cmd_col        <= want_col[sel_idx];
            cmd_data       <= (want_kind[sel_idx] == CMD_WRITE) ? want_data[sel_idx] : '0;
        end
    end

endmodule

// ==== logic/request_scheduler.sv ====
module request_scheduler import sched_pkg::*; (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 req_valid,
    input  logic                 req_write,
    input  logic [ADDR_BITS-1:0] req_addr,
    input  logic [DATA_BITS-1:0] req_data,
    output logic                 req_ready,
    output logic                 cmd_valid,
    output cmd_e                 cmd_kind,
    output logic [BG_BITS-1:0]   cmd_bank_group,
    output logic [BA_BITS-1:0]   cmd_bank,
    output logic [ROW_BITS-1:0]  cmd_row,
    output logic [COL_BITS-1:0]  cmd_col,
    output logic [DATA_BITS-1:0] cmd_data,
    input  logic                 cmd_ready
);

    logic [ROW_BITS-1:0]  dec_row;
    logic [COL_BITS-1:0]  dec_col;
    logic [BANK_BITS-1:0] dec_bank_index;
    logic [NUM_BANKS-1:0] push;
    logic [NUM_BANKS-1:0] full;

    // queue heads
    logic [NUM_BANKS-1:0] head_valid;
    logic [NUM_BANKS-1:0] head_write;
    logic [ROW_BITS-1:0]  head_row  [NUM_BANKS];
    logic [COL_BITS-1:0]  head_col  [NUM_BANKS];
    logic [DATA_BITS-1:0] head_data [NUM_BANKS];
    logic [NUM_BANKS-1:0] pop;

    // controller requests and arbiter replies
    logic [NUM_BANKS-1:0] want;
    cmd_e                 want_kind [NUM_BANKS];
    logic [ROW_BITS-1:0]  want_row  [NUM_BANKS];
    logic [COL_BITS-1:0]  want_col  [NUM_BANKS];
    logic [DATA_BITS-1:0] want_data [NUM_BANKS];
    logic [NUM_BANKS-1:0] grant;
    logic [NUM_BANKS-1:0] issued;

    address_decoder decoder0 (
        .addr       (req_addr),
        .req_valid  (req_valid),
        .bank_group (),
        .bank       (),
        .row        (dec_row),
        .col        (dec_col),
        .bank_index (dec_bank_index),
        .push       (push)
    );

    assign req_ready = !full[dec_bank_index];  // only the target queue matters

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        bank_request_fifo fifo0 (
            .clk_in     (clk_in),
            .rst_in     (rst_in),
            .push       (push[b]),
            .write      (req_write),
            .row        (dec_row),
            .col        (dec_col),
            .data       (req_data),
            .pop        (pop[b]),
            .full       (full[b]),
            .head_valid (head_valid[b]),
            .head_write (head_write[b]),
            .head_row   (head_row[b]),
            .head_col   (head_col[b]),
            .head_data  (head_data[b])
        );

        bank_controller ctrl0 (
            .clk_in     (clk_in),
            .rst_in     (rst_in),
            .head_valid (head_valid[b]),
            .head_write (head_write[b]),
            .head_row   (head_row[b]),
            .head_col   (head_col[b]),
            .head_data  (head_data[b]),
            .grant      (grant[b]),
            .issued     (issued[b]),
            .pop        (pop[b]),
            .want       (want[b]),
            .want_kind  (want_kind[b]),
            .want_row   (want_row[b]),
            .want_col   (want_col[b]),
            .want_data  (want_data[b])
        );
    end

    command_arbiter arbiter0 (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .want           (want),
        .want_kind      (want_kind),
        .want_row       (want_row),
        .want_col       (want_col),
        .want_data      (want_data),
        .cmd_ready      (cmd_ready),
        .grant          (grant),
        .issued         (issued),
        .cmd_valid      (cmd_valid),
        .cmd_kind       (cmd_kind),
        .cmd_bank_group (cmd_bank_group),
        .cmd_bank       (cmd_bank),
        .cmd_row        (cmd_row),
        .cmd_col        (cmd_col),
        .cmd_data       (cmd_data)
    );

endmodule

// ==== logic/sched_pkg.sv ====
package sched_pkg;

    // chip geometry
    localparam int BANK_GROUPS     = 2;
    localparam int BANKS_PER_GROUP = 2;
    localparam int NUM_BANKS       = BANK_GROUPS * BANKS_PER_GROUP;

    localparam int BG_BITS   = 1;                  // bank group index
    localparam int BA_BITS   = 1;                  // bank index inside a group
    localparam int BANK_BITS = BG_BITS + BA_BITS;  // flat bank index

    localparam int ROW_BITS  = 8;
    localparam int COL_BITS  = 4;

    // address layout, msb first: bank group, bank, row, column
    localparam int ADDR_BITS = BG_BITS + BA_BITS + ROW_BITS + COL_BITS;

    localparam int DATA_BITS = 32;

    // per-bank request queue
    localparam int FIFO_DEPTH = 4;
    localparam int PTR_BITS   = $clog2(FIFO_DEPTH);

    // minimum spacing between handshakes on one bank
    localparam int PRECHARGE_CYCLES = 5;  // precharge to activate
    localparam int ACTIVATE_CYCLES  = 8;  // activate to read or write

    // wide enough for the longer of the two latencies
    localparam int TIMER_BITS = $clog2(ACTIVATE_CYCLES + 1);

    // command encoding on the output
    typedef enum logic [1:0] {
        CMD_READ      = 2'd0,
        CMD_WRITE     = 2'd1,
        CMD_ACTIVATE  = 2'd2,
        CMD_PRECHARGE = 2'd3
    } cmd_e;

endpackage

// ==== verification/dram_bank_model.svh ====
`ifndef DRAM_BANK_MODEL_SVH
`define DRAM_BANK_MODEL_SVH

// number of commands one request needs, from the bank's open row
// 1 row hit, 2 closed bank, 3 row miss
function automatic int predict_count(
    input logic                open,
    input logic [ROW_BITS-1:0] open_row,
    input logic [ROW_BITS-1:0] row
);
    if (!open) begin
        return 2;
    end else if (open_row == row) begin
        return 1;
    end
    return 3;
endfunction

// kind of the command at position step in a sequence of n commands
function automatic cmd_e sequence_kind(input int n, input int step, input logic write);
    if (step == n - 1) begin
        return write ? CMD_WRITE : CMD_READ;  // access always comes last
    end else if (step == n - 2) begin
        return CMD_ACTIVATE;
    end
    return CMD_PRECHARGE;
endfunction

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

`endif

// ==== verification/request_scheduler_tb.sv ====
module request_scheduler_tb import sched_pkg::*; ();

    localparam int NUM_ROWS        = 16;
    localparam int BURST_START     = 10;  // rows from here on all go to bank 2
    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + NUM_ROWS * (PRECHARGE_CYCLES + ACTIVATE_CYCLES + 20);

    typedef struct packed {
        logic                 write;
        logic [BG_BITS-1:0]   bg;
        logic [BA_BITS-1:0]   ba;
        logic [ROW_BITS-1:0]  row;
        logic [COL_BITS-1:0]  col;
        logic [DATA_BITS-1:0] data;
        logic [1:0]           ncmd;  // 1 hit, 2 closed bank, 3 row miss
    } stim_t;

    typedef struct packed {
        cmd_e                 kind;
        logic [ROW_BITS-1:0]  row;
        logic [COL_BITS-1:0]  col;
        logic [DATA_BITS-1:0] data;
    } exp_t;

    // write, bank group, bank, row, column, data, command count
    stim_t table_rows [NUM_ROWS] = '{
        '{1'b0, 1'b0, 1'b0, 8'h10, 4'h1, 32'h7777_0001, 2'd2},
        '{1'b1, 1'b0, 1'b0, 8'h10, 4'h2, 32'hcafe_0001, 2'd1},
        '{1'b1, 1'b1, 1'b0, 8'h22, 4'h3, 32'h1234_5678, 2'd2},
        '{1'b0, 1'b0, 1'b0, 8'h11, 4'h4, 32'h7777_0003, 2'd3},
        '{1'b1, 1'b0, 1'b1, 8'h35, 4'h5, 32'h5a5a_a5a5, 2'd2},
        '{1'b0, 1'b1, 1'b1, 8'h47, 4'h6, 32'h7777_0005, 2'd2},
        '{1'b1, 1'b1, 1'b1, 8'h47, 4'h7, 32'hdead_beef, 2'd1},
        '{1'b0, 1'b1, 1'b0, 8'h23, 4'h8, 32'h7777_0007, 2'd3},
        '{1'b1, 1'b0, 1'b1, 8'h35, 4'h9, 32'h0f0f_0f0f, 2'd1},
        '{1'b1, 1'b1, 1'b1, 8'h48, 4'ha, 32'h8000_0001, 2'd3},
        '{1'b1, 1'b1, 1'b0, 8'h23, 4'h0, 32'h1111_2222, 2'd1},
        '{1'b0, 1'b1, 1'b0, 8'h23, 4'h1, 32'h7777_000b, 2'd1},
        '{1'b1, 1'b1, 1'b0, 8'h50, 4'h2, 32'h3333_4444, 2'd3},
        '{1'b0, 1'b1, 1'b0, 8'h50, 4'h3, 32'h7777_000d, 2'd1},
        '{1'b1, 1'b1, 1'b0, 8'h23, 4'h4, 32'h5555_6666, 2'd3},
        '{1'b0, 1'b1, 1'b0, 8'h23, 4'h5, 32'h7777_000f, 2'd1}
    };

    logic                 clk_in;
    logic                 rst_in;
    logic                 req_valid;
    logic                 req_write;
    logic [ADDR_BITS-1:0] req_addr;
    logic [DATA_BITS-1:0] req_data;
    logic                 req_ready;
    logic                 cmd_valid;
    cmd_e                 cmd_kind;
    logic [BG_BITS-1:0]   cmd_bank_group;
    logic [BA_BITS-1:0]   cmd_bank;
    logic [ROW_BITS-1:0]  cmd_row;
    logic [COL_BITS-1:0]  cmd_col;
    logic [DATA_BITS-1:0] cmd_data;
    logic                 cmd_ready;

    exp_t                exp_q [NUM_BANKS][$];  // expected commands per bank
    logic                model_open [NUM_BANKS] = '{default: 1'b0};
    logic [ROW_BITS-1:0] model_row  [NUM_BANKS] = '{default: '0};
    int                  last_pre   [NUM_BANKS] = '{default: -100};
    int                  last_act   [NUM_BANKS] = '{default: -100};
    int                  cycle  = 0;
    int                  errors = 0;
    int                  checks = 0;
    logic                stall  = 1'b0;  // forces cmd_ready low
    logic                held   = 1'b0;
    logic [48:0]         held_word;
    logic [48:0]         cur_word;
    logic [15:0]         lfsr;

    `include "dram_bank_model.svh"

    request_scheduler dut0 (.*);

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic int pending_commands();
        int total;
        total = 0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            total += exp_q[b].size();
        end
        return total;
    endfunction

    task automatic wait_drain();
        while (pending_commands() != 0) begin
            @(negedge clk_in);
        end
    endtask

    // drives one table row at a falling edge and waits for its transfer
    task automatic apply_row(input int i);
        stim_t r;
        exp_t  e;
        int    n;
        int    b;
        r = table_rows[i];
        b = {r.bg, r.ba};
        n = predict_count(model_open[b], model_row[b], r.row);
        check_value($sformatf("table row %0d sequence", i), r.ncmd, n);
        req_write = r.write;
        req_addr  = {r.bg, r.ba, r.row, r.col};
        req_data  = r.data;
        req_valid = 1'b1;
        if (i == BURST_START + FIFO_DEPTH) begin
            repeat (3) @(negedge clk_in);
            check_value("req_ready on full queue", 0, req_ready);
            @(posedge clk_in);
            stall = 1'b0;
        end
        @(posedge clk_in);
        while (!req_ready) begin
            @(posedge clk_in);
        end
        for (int s = 0; s < n; s++) begin
            e.kind = sequence_kind(n, s, r.write);
            e.row  = r.row;
            e.col  = r.col;
            e.data = (e.kind == CMD_WRITE) ? r.data : '0;
            exp_q[b].push_back(e);
        end
        model_open[b] = 1'b1;
        model_row[b]  = r.row;
        @(negedge clk_in);
        req_valid = 1'b0;
    endtask

    task automatic check_command();
        exp_t e;
        int   b;
        b = {cmd_bank_group, cmd_bank};
        if (exp_q[b].size() == 0) begin
            $display("command on bank %0d arrived with no request pending for it", b);
            errors++;
        end else begin
            e = exp_q[b].pop_front();
            check_value($sformatf("bank %0d kind", b), e.kind, cmd_kind);
            check_value($sformatf("bank %0d row", b), e.row, cmd_row);
            check_value($sformatf("bank %0d col", b), e.col, cmd_col);
            check_value($sformatf("bank %0d data", b), e.data, cmd_data);
        end
        if (cmd_kind == CMD_PRECHARGE) begin
            last_pre[b] = cycle;
        end else if (cmd_kind == CMD_ACTIVATE) begin
            check_value($sformatf("bank %0d precharge gap ok", b), 1,
                        (cycle - last_pre[b]) >= PRECHARGE_CYCLES);
            last_act[b] = cycle;
        end else begin
            check_value($sformatf("bank %0d activate gap ok", b), 1,
                        (cycle - last_act[b]) >= ACTIVATE_CYCLES);
        end
    endtask

    // output monitor sampling on the rising edge
    always @(posedge clk_in) begin
        if (!rst_in) begin
            cycle++;
            cur_word = {cmd_valid, cmd_kind, cmd_bank_group, cmd_bank, cmd_row, cmd_col,
                        cmd_data};
            if (held) begin
                check_value("held command stable", held_word, cur_word);
            end
            held      = cmd_valid && !cmd_ready;
            held_word = cur_word;
            if (cmd_valid && cmd_ready) begin
                check_command();
            end
        end
    end

    // random sink back-pressure
    initial begin
        cmd_ready = 1'b0;
        lfsr      = 16'd38976;
        forever begin
            @(negedge clk_in);
            if (stall) begin
                cmd_ready = 1'b0;
            end else begin
                lfsr      = lfsr_next(lfsr);
                cmd_ready = lfsr[0];
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("timeout after %0d cycles, commands still pending", WATCHDOG_CYCLES);
        $display("checks %0d errors %0d", checks, errors + 1);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_in    = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_data  = '0;
        repeat (RESET_CYCLES) begin
            @(negedge clk_in);
            check_value("cmd_valid during reset", 0, cmd_valid);
        end
        rst_in = 1'b0;
        @(negedge clk_in);
        check_value("cmd_valid after reset", 0, cmd_valid);
        for (int i = 0; i < BURST_START; i++) begin
            apply_row(i);
        end
        wait_drain();
        @(posedge clk_in);
        stall = 1'b1;  // output blocked so bank 2 fills up
        @(negedge clk_in);
        for (int i = BURST_START; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        wait_drain();
        repeat (20) @(negedge clk_in);  // room for a stray duplicate
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
